//--- rtl/dma_bus_master_top.sv
`timescale 1ns/100ps
// DMA bus master between the host DMA engine and the remote packet chip
// Single clock, nreset also covers reprogramming of the remote chip
// Host pulses dma_rd_request only after dma_all_in_buf of the last one
module dma_bus_master_top
   import dma_pkg::*;
(
   input  logic                  nclk,
   input  logic                  nreset,
   // Host receive side
   input  logic                  dma_rd_request,
   input  logic [queue_w-1:0]    dma_rd_queue,
   input  logic                  dma_rd_en,
   output logic [data_w-1:0]     dma_rd_data,
   output logic                  dma_empty,
   output logic                  dma_nearly_empty,
   output logic                  dma_all_in_buf,
   output logic                  overflow,
   // Host status view
   output logic [num_queues-1:0] dma_pkt_avail,
   output logic [num_queues-1:0] dma_can_wr_pkt,
   output logic                  dma_queue_info_avail,
   // Host transmit side
   input  logic [data_w-1:0]     dma_wr_data,
   input  logic                  dma_wr_en,
   output logic                  dma_wr_rdy,
   // Link to remote chip
   output logic [1:0]            link_op_req,
   output logic [queue_w-1:0]    link_op_queue,
   input  logic [1:0]            link_op_ack,
   input  logic                  link_vld_in,
   input  logic [data_w-1:0]     link_data_in,
   output logic                  link_nearly_full_out,
   output logic                  link_vld_out,
   output logic [data_w-1:0]     link_data_out,
   input  logic                  link_nearly_full_in
);

   // Tracker and sequencer handshake
   logic               rx_req, tx_req, new_request, tx_active;
   logic               clr_rx_req, clr_tx_req;
   logic [queue_w-1:0] rx_queue;
   // Counter controls and results
   logic               ld_rx, ld_tx, inc, all_in_buf, nearly_all_in_buf;
   link_word_u         link_word;
   // FIFO connections
   logic [data_w-1:0]  tx_head, rx_wr_data;
   logic               tx_rd_en, tx_empty, tx_nearly_full;
   logic               rx_wr_en, rx_full, rx_nearly_full;

   // Host may write while the transmit FIFO has headroom
   assign dma_wr_rdy     = !tx_nearly_full;
   assign dma_all_in_buf = all_in_buf;
   // Any transfer on the link holds off a new transmit request
   assign tx_active      = (link_op_req != op_status_query);

   dma_link_sequencer  u_sequencer (.*);
   dma_word_counter    u_counter   (.*);
   dma_request_tracker u_tracker   (.*);

   // Host to link, header word at the head
   dma_sync_fifo #(.depth(tx_fifo_depth), .nearly_full_level(tx_nearly_full_level)) u_tx_fifo (
      .nclk         (nclk),
      .nreset       (nreset),
      .wr_en        (dma_wr_en),
      .wr_data      (dma_wr_data),
      .rd_en        (tx_rd_en),
      .rd_data      (tx_head),
      .empty        (tx_empty),
      .full         (),
      .nearly_full  (tx_nearly_full),
      .nearly_empty ()
   );

   // Link to host, length word first
   dma_sync_fifo #(.depth(rx_fifo_depth), .nearly_full_level(rx_nearly_full_level)) u_rx_fifo (
      .nclk         (nclk),
      .nreset       (nreset),
      .wr_en        (rx_wr_en),
      .wr_data      (rx_wr_data),
      .rd_en        (dma_rd_en),
      .rd_data      (dma_rd_data),
      .empty        (dma_empty),
      .full         (rx_full),
      .nearly_full  (rx_nearly_full),
      .nearly_empty (dma_nearly_empty)
   );

endmodule

//--- rtl/dma_link_sequencer.sv
`timescale 1ns/100ps
// Link FSM: status polling, one receive or one transmit at a time
// Received words are dropped, not stalled, when the receive FIFO is full
// Zero-length transmits are not supported
module dma_link_sequencer
   import dma_pkg::*;
(
   input  logic                  nclk,
   input  logic                  nreset,
   input  logic [1:0]            link_op_ack,
   input  logic                  link_vld_in,
   input  logic [data_w-1:0]     link_data_in,
   input  logic                  link_nearly_full_in,
   input  logic                  rx_req,
   input  logic [queue_w-1:0]    rx_queue,
   input  logic                  tx_req,
   input  logic                  all_in_buf,
   input  logic                  nearly_all_in_buf,
   input  logic [data_w-1:0]     tx_head,
   input  logic                  tx_empty,
   input  logic                  rx_full,
   input  logic                  rx_nearly_full,
   output logic [1:0]            link_op_req,
   output logic [queue_w-1:0]    link_op_queue,
   output logic                  link_vld_out,
   output logic [data_w-1:0]     link_data_out,
   output logic                  link_nearly_full_out,
   output logic [num_queues-1:0] dma_pkt_avail,
   output logic [num_queues-1:0] dma_can_wr_pkt,
   output logic                  dma_queue_info_avail,
   output logic                  overflow,
   output link_word_u            link_word,
   output logic                  ld_rx,
   output logic                  ld_tx,
   output logic                  inc,
   output logic                  clr_rx_req,
   output logic                  clr_tx_req,
   output logic                  tx_rd_en,
   output logic                  rx_wr_en,
   output logic [data_w-1:0]     rx_wr_data
);

   logic [1:0]            ack_d1, op_req_nxt;
   logic                  vld_d1, nf_in_d1, vld_out_nxt, info_avail_nxt, see_overflow;
   logic [2:0]            state, state_nxt;
   logic [queue_w-1:0]    op_queue_nxt;
   logic [data_w-1:0]     data_out_nxt;
   logic [num_queues-1:0] pkt_avail_nxt, can_wr_nxt;
   logic [ovf_cnt_w-1:0]  ovf_cnt;

   // ======================================================================
   // Input flops, every link input is seen one cycle late
   // ======================================================================
   always_ff @(posedge nclk) begin
      if (nreset) begin
         ack_d1   <= op_idle;
         vld_d1   <= 1'b0;
         nf_in_d1 <= 1'b0;
      end else begin
         ack_d1   <= link_op_ack;
         vld_d1   <= link_vld_in;
         nf_in_d1 <= link_nearly_full_in;
      end
   end

   always_ff @(posedge nclk) begin
      link_word     <= link_data_in;
      link_data_out <= data_out_nxt;
   end

   // Received words go straight to the receive FIFO
   assign rx_wr_data = link_word;

   // ======================================================================
   // Next-state logic
   // ======================================================================
   always_comb begin
      state_nxt      = state;
      op_req_nxt     = link_op_req;
      op_queue_nxt   = link_op_queue;
      vld_out_nxt    = link_vld_out;
      data_out_nxt   = link_data_out;
      pkt_avail_nxt  = dma_pkt_avail;
      can_wr_nxt     = dma_can_wr_pkt;
      info_avail_nxt = 1'b0;
      clr_rx_req     = 1'b0;
      clr_tx_req     = 1'b0;
      ld_rx          = 1'b0;
      ld_tx          = 1'b0;
      inc            = 1'b0;
      tx_rd_en       = 1'b0;
      rx_wr_en       = 1'b0;
      see_overflow   = 1'b0;
      case (state)
         st_query_req: begin
            op_req_nxt  = op_status_query;
            vld_out_nxt = 1'b0;
            state_nxt   = st_query_ack;
         end
         st_query_ack: begin
            // Status answer carries both queue masks
            if (ack_d1 == op_status_query && vld_d1) begin
               pkt_avail_nxt  = link_word.status.pkt_avail;
               can_wr_nxt     = link_word.status.can_wr_pkt;
               info_avail_nxt = 1'b1;
            end
            // Leave only once the remote side has moved to the query
            if (ack_d1 == op_status_query && rx_req) begin
               op_queue_nxt = rx_queue;
               state_nxt    = st_rx_req;
            end else if (ack_d1 == op_status_query && tx_req) begin
               op_queue_nxt = tx_head[19:16];
               state_nxt    = st_tx_req;
            end
         end
         st_rx_req: begin
            op_req_nxt = op_net_to_cpci;
            if (ack_d1 == op_net_to_cpci) begin
               clr_rx_req = 1'b1;
               state_nxt  = st_rx_len;
            end
         end
         // First word is the byte length, stored like payload
         st_rx_len: if (vld_d1) begin
            ld_rx        = 1'b1;
            rx_wr_en     = !rx_full;
            see_overflow = rx_full;
            state_nxt    = st_rx_data;
         end
         st_rx_data: begin
            if (vld_d1) begin
               rx_wr_en     = !rx_full;
               see_overflow = rx_full;
               inc          = 1'b1;
            end
            if (all_in_buf) state_nxt = st_query_req;
         end
         st_tx_req: begin
            op_req_nxt = op_cpci_to_net;
            // Header leaves as a zero-extended length word
            // Held back by remote back-pressure like any payload word
            if (ack_d1 == op_cpci_to_net && !nf_in_d1) begin
               clr_tx_req   = 1'b1;
               ld_tx        = 1'b1;
               tx_rd_en     = 1'b1;
               data_out_nxt = {{(data_w-16){1'b0}}, tx_head[15:0]};
               vld_out_nxt  = 1'b1;
               state_nxt    = st_tx_len_data;
            end
         end
         st_tx_len_data: begin
            // Remote chip back-pressure pauses the stream
            if (nf_in_d1) begin
               vld_out_nxt = 1'b0;
            end else begin
               data_out_nxt = tx_head;
               vld_out_nxt  = !tx_empty;
               tx_rd_en     = !tx_empty;
               inc          = !tx_empty;
               if (nearly_all_in_buf && !tx_empty) state_nxt = st_query_req;
            end
         end
         default: begin
            op_req_nxt = op_idle;
            state_nxt  = st_query_req;
         end
      endcase
   end

   always_ff @(posedge nclk) begin
      if (nreset) begin
         state                <= st_query_req;
         link_op_req          <= op_status_query;
         link_op_queue        <= '0;
         link_vld_out         <= 1'b0;
         link_nearly_full_out <= 1'b0;
         dma_pkt_avail        <= '0;
         dma_can_wr_pkt       <= '0;
         dma_queue_info_avail <= 1'b0;
      end else begin
         state                <= state_nxt;
         link_op_req          <= op_req_nxt;
         link_op_queue        <= op_queue_nxt;
         link_vld_out         <= vld_out_nxt;
         link_nearly_full_out <= rx_nearly_full;
         dma_pkt_avail        <= pkt_avail_nxt;
         dma_can_wr_pkt       <= can_wr_nxt;
         dma_queue_info_avail <= info_avail_nxt;
      end
   end

   // ======================================================================
   // Overflow stretch, held overflow_hold cycles after the last drop
   // ======================================================================
   always_ff @(posedge nclk) begin
      if (nreset) begin
         overflow <= 1'b0;
         ovf_cnt  <= '0;
      end else if (see_overflow) begin
         overflow <= 1'b1;
         ovf_cnt  <= ovf_cnt_w'(overflow_hold - 1);
      end else if (ovf_cnt == '0) begin
         overflow <= 1'b0;
      end else begin
         ovf_cnt <= ovf_cnt - 1'b1;
      end
   end

endmodule

//--- rtl/dma_pkg.sv
// Shared widths, link opcodes, FIFO sizes and link word layout
// Byte lengths above 2044 do not fit the 9-bit word counters
// Transmit header layout: bits 19:16 queue, bits 15:0 byte length
package dma_pkg;

   // ======================================================================
   // Widths and sizes
   // ======================================================================
   localparam int data_w     = 32;
   localparam int queue_w    = 4;
   localparam int num_queues = 16;
   localparam int len_w      = 11;
   localparam int word_cnt_w = 9;

   // FIFO sizing, depths must be powers of two
   localparam int tx_fifo_depth        = 16;
   localparam int tx_nearly_full_level = 12;
   localparam int rx_fifo_depth        = 32;
   localparam int rx_nearly_full_level = 28;
   localparam int nearly_empty_level   = 3;

   // Overflow flag stretch
   localparam int overflow_hold = 4;
   localparam int ovf_cnt_w     = $clog2(overflow_hold);

   // Link opcodes, used on both request and acknowledge
   localparam logic [1:0] op_idle         = 2'b00;
   localparam logic [1:0] op_status_query = 2'b01;
   localparam logic [1:0] op_cpci_to_net  = 2'b10;
   localparam logic [1:0] op_net_to_cpci  = 2'b11;

   // Sequencer state codes
   localparam logic [2:0] st_query_req    = 3'd0;
   localparam logic [2:0] st_query_ack    = 3'd1;
   localparam logic [2:0] st_rx_req       = 3'd2;
   localparam logic [2:0] st_rx_len       = 3'd3;
   localparam logic [2:0] st_rx_data      = 3'd4;
   localparam logic [2:0] st_tx_req       = 3'd5;
   localparam logic [2:0] st_tx_len_data  = 3'd6;

   // Incoming link word, status answer or receive length word
   typedef union packed {
      struct packed {
         logic [num_queues-1:0] pkt_avail;
         logic [num_queues-1:0] can_wr_pkt;
      } status;
      struct packed {
         logic [data_w-len_w-1:0] unused;
         logic [len_w-1:0]        byte_len;
      } len;
   } link_word_u;

endpackage

//--- rtl/dma_request_tracker.sv
`timescale 1ns/100ps
// Holds pending receive and transmit requests for the link FSM
// A second receive pulse before dma_all_in_buf is not supported
module dma_request_tracker
   import dma_pkg::*;
(
   input  logic               nclk,
   input  logic               nreset,
   input  logic               dma_rd_request,
   input  logic [queue_w-1:0] dma_rd_queue,
   input  logic               clr_rx_req,
   input  logic               clr_tx_req,
   input  logic               tx_empty,
   input  logic               tx_active,
   output logic               rx_req,
   output logic [queue_w-1:0] rx_queue,
   output logic               tx_req,
   output logic               new_request
);

   logic tx_ready;

   // Transmit FIFO has a header waiting and the link is free
   assign tx_ready = !tx_empty && !tx_active;

   // Receive request held until the FSM has the acknowledge
   always_ff @(posedge nclk) begin
      if (nreset || clr_rx_req) rx_req <= 1'b0;
      else if (dma_rd_request) rx_req <= 1'b1;
   end

   // Queue number sampled with the request pulse
   always_ff @(posedge nclk) begin
      if (dma_rd_request) rx_queue <= dma_rd_queue;
   end

   always_ff @(posedge nclk) begin
      if (nreset || clr_tx_req) tx_req <= 1'b0;
      else if (tx_ready) tx_req <= 1'b1;
   end

   // Restarts the word counter, only on the first cycle of a request
   assign new_request = dma_rd_request || (tx_ready && !tx_req);

endmodule

//--- rtl/dma_sync_fifo.sv
`timescale 1ns/100ps
// Single-clock FIFO with first-word fall-through read data
// depth must be a power of two; writes when full and reads when empty are ignored
module dma_sync_fifo
   import dma_pkg::*;
#(
   parameter int depth             = 16,
   parameter int nearly_full_level = 12
) (
   input  logic              nclk,
   input  logic              nreset,
   input  logic              wr_en,
   input  logic [data_w-1:0] wr_data,
   input  logic              rd_en,
   output logic [data_w-1:0] rd_data,
   output logic              empty,
   output logic              full,
   output logic              nearly_full,
   output logic              nearly_empty
);

   logic [data_w-1:0]          mem [depth];
   logic [$clog2(depth)-1:0]   wr_ptr;
   logic [$clog2(depth)-1:0]   rd_ptr;
   logic [$clog2(depth+1)-1:0] count;
   logic                       do_wr;
   logic                       do_rd;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Storage
   always_ff @(posedge nclk) begin
      if (do_wr) mem[wr_ptr] <= wr_data;
   end

   // Pointers wrap naturally
   always_ff @(posedge nclk) begin
      if (nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         // Occupancy, unchanged on simultaneous read and write
         if (do_wr && !do_rd) count <= count + 1'b1;
         else if (do_rd && !do_wr) count <= count - 1'b1;
      end
   end

   // Head word is visible whenever not empty
   assign rd_data      = mem[rd_ptr];
   assign empty        = (count == '0);
   assign full         = (count == depth);
   assign nearly_full  = (count >= nearly_full_level);
   assign nearly_empty = (count <= nearly_empty_level);

endmodule

//--- rtl/dma_word_counter.sv
`timescale 1ns/100ps
// Expected and running word counts for one transfer
// Expected count is all ones between a new request and the length load
module dma_word_counter
   import dma_pkg::*;
(
   input  logic              nclk,
   input  logic              nreset,
   input  logic              new_request,
   input  logic              ld_rx,
   input  logic              ld_tx,
   input  logic              inc,
   input  link_word_u        link_word,
   input  logic [data_w-1:0] tx_head,
   output logic              all_in_buf,
   output logic              nearly_all_in_buf
);

   logic [word_cnt_w-1:0] expect_cnt;
   logic [word_cnt_w-1:0] word_cnt;
   logic [len_w-1:0]      load_len;
   logic [word_cnt_w-1:0] load_words;

   // Receive length from the link, transmit length from the header
   assign load_len   = ld_rx ? link_word.len.byte_len : tx_head[len_w-1:0];
   // Bytes to words, rounded up
   assign load_words = load_len[len_w-1:2] + word_cnt_w'(load_len[1:0] != 2'b00);

   always_ff @(posedge nclk) begin
      if (nreset || new_request) begin
         expect_cnt <= '1;
         word_cnt   <= '0;
      end else if (ld_rx || ld_tx) begin
         expect_cnt <= load_words;
         word_cnt   <= '0;
      end else if (inc) begin
         word_cnt <= word_cnt + 1'b1;
      end
   end

   // Done, and one word short of done for the transmit stream
   assign all_in_buf        = (word_cnt == expect_cnt);
   assign nearly_all_in_buf = (word_cnt == expect_cnt - 1'b1);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DMA bus master testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module dma_bus_master_tb -o sim_dma
./obj_dir/sim_dma 2>&1 | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- sim.f
rtl/dma_pkg.sv
rtl/dma_sync_fifo.sv
rtl/dma_word_counter.sv
rtl/dma_request_tracker.sv
rtl/dma_link_sequencer.sv
rtl/dma_bus_master_top.sv
verif/dma_bus_master_assertions.sv
verif/dma_bus_master_tb.sv

//--- verif/dma_bus_master_assertions.sv
`timescale 1ns/100ps
// Link and overflow rules, bound into dma_bus_master_top
// Back-pressure rule covers the header word and every payload word
module dma_bus_master_assertions
   import dma_pkg::*;
(
   input logic nclk,
   input logic nreset,
   input logic link_vld_out,
   input logic link_nearly_full_in,
   input logic overflow,
   input logic dma_queue_info_avail
);

   logic nf_d1;

   // Same one-cycle flop that the sequencer sees
   always_ff @(posedge nclk) begin
      if (nreset) nf_d1 <= 1'b0;
      else nf_d1 <= link_nearly_full_in;
   end

   // No word goes out after a flopped nearly-full
   nf_blocks_vld: assert property (@(posedge nclk) disable iff (nreset)
      nf_d1 |=> !link_vld_out)
      else $error("link_vld_out high after flopped link_nearly_full_in");

   // Overflow stretch length
   overflow_held: assert property (@(posedge nclk) disable iff (nreset)
      $rose(overflow) |-> overflow [*overflow_hold])
      else $error("overflow dropped before the hold time");

   // Status pulse is one cycle wide
   info_pulse: assert property (@(posedge nclk) disable iff (nreset)
      dma_queue_info_avail |=> !dma_queue_info_avail)
      else $error("dma_queue_info_avail high for more than one cycle");

endmodule

bind dma_bus_master_top dma_bus_master_assertions u_assertions (
   .nclk                 (nclk),
   .nreset               (nreset),
   .link_vld_out         (link_vld_out),
   .link_nearly_full_in  (link_nearly_full_in),
   .overflow             (overflow),
   .dma_queue_info_avail (dma_queue_info_avail)
);

//--- verif/dma_bus_master_tb.sv
`timescale 1ns/100ps
// Testbench for dma_bus_master_top, steps come from verif/dma_testdata.txt
// Run from the project root so the data file path resolves
// Remote chip model acks every opcode and streams receive words back to back
module dma_bus_master_tb;
   import dma_pkg::*;

   localparam int max_steps = 64;

   logic                  nclk, nreset;
   logic                  dma_rd_request, dma_rd_en, dma_wr_en;
   logic [queue_w-1:0]    dma_rd_queue;
   logic [data_w-1:0]     dma_wr_data, dma_rd_data;
   logic                  dma_empty, dma_nearly_empty, dma_all_in_buf, overflow, dma_wr_rdy;
   logic [num_queues-1:0] dma_pkt_avail, dma_can_wr_pkt;
   logic                  dma_queue_info_avail;
   logic [1:0]            link_op_req, link_op_ack;
   logic [queue_w-1:0]    link_op_queue;
   logic                  link_vld_in, link_nearly_full_out, link_vld_out, link_nearly_full_in;
   logic [data_w-1:0]     link_data_in, link_data_out;

   // Steps read from the data file
   byte                   step_kind [max_steps];
   logic [queue_w-1:0]    step_queue [max_steps];
   int                    step_len [max_steps];
   logic [data_w-1:0]     step_status [max_steps];
   int                    num_steps;

   int                    mismatches, failures, cycles, cycle_limit, burst_left;
   logic [31:0]           lfsr_state;
   logic                  nf_enable, saw_overflow;
   logic [data_w-1:0]     link_seen [$];

   dma_bus_master_top u_dut (
      .nclk(nclk), .nreset(nreset),
      .dma_rd_request(dma_rd_request), .dma_rd_queue(dma_rd_queue), .dma_rd_en(dma_rd_en),
      .dma_rd_data(dma_rd_data), .dma_empty(dma_empty), .dma_nearly_empty(dma_nearly_empty),
      .dma_all_in_buf(dma_all_in_buf), .overflow(overflow),
      .dma_pkt_avail(dma_pkt_avail), .dma_can_wr_pkt(dma_can_wr_pkt),
      .dma_queue_info_avail(dma_queue_info_avail),
      .dma_wr_data(dma_wr_data), .dma_wr_en(dma_wr_en), .dma_wr_rdy(dma_wr_rdy),
      .link_op_req(link_op_req), .link_op_queue(link_op_queue), .link_op_ack(link_op_ack),
      .link_vld_in(link_vld_in), .link_data_in(link_data_in),
      .link_nearly_full_out(link_nearly_full_out), .link_vld_out(link_vld_out),
      .link_data_out(link_data_out), .link_nearly_full_in(link_nearly_full_in)
   );

   // ======================================================================
   // Clock, watchdog and LFSR
   // ======================================================================
   always #20 nclk = ~nclk;

   always @(posedge nclk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("=== FAIL ===");
         $finish;
      end
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic take_bit();
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      return lfsr_state[0];
   endfunction

   function automatic logic [31:0] take_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++) w = {w[30:0], take_bit()};
      return w;
   endfunction

   // ======================================================================
   // Remote chip model
   // ======================================================================
   // Ack mirrors the request one cycle later
   always @(negedge nclk) begin
      if (nreset) link_op_ack <= op_idle;
      else link_op_ack <= link_op_req;
   end

   // Back-pressure bursts of 3 cycles while a transmit is streaming
   always @(negedge nclk) begin
      if (!nf_enable) begin
         burst_left = 0;
         link_nearly_full_in <= 1'b0;
      end else if (burst_left > 0) begin
         burst_left = burst_left - 1;
         link_nearly_full_in <= 1'b1;
      end else if (take_bit() && take_bit()) begin
         burst_left = 2;
         link_nearly_full_in <= 1'b1;
      end else begin
         link_nearly_full_in <= 1'b0;
      end
   end

   // Sticky record of the overflow flag for the current receive
   always @(posedge nclk) begin
      if (overflow === 1'b1) saw_overflow = 1'b1;
   end

   // ======================================================================
   // Helpers
   // ======================================================================
   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] got);
      mismatches++;
      $display("mismatch at %0t ns: %s expected %h got %h", $time, what, exp, got);
   endtask

   task automatic report_failure(input string what);
      failures++;
      $display("error at %0t ns: %s", $time, what);
   endtask

   task automatic read_steps();
      int    fd, n;
      string line, kind;
      logic [31:0] q, st;
      int    len;
      fd = $fopen("verif/dma_testdata.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open verif/dma_testdata.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // Skip comments and blank lines
         if (line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%s %h %d %h", kind, q, len, st);
         if (n == 4 && num_steps < max_steps) begin
            step_kind[num_steps]   = kind[0];
            step_queue[num_steps]  = q[queue_w-1:0];
            step_len[num_steps]    = len;
            step_status[num_steps] = st;
            num_steps++;
         end
      end
      $fclose(fd);
   endtask

   // Link back in status polling with the ack caught up
   task automatic wait_link_idle();
      while (!(link_op_req == op_status_query && link_op_ack == op_status_query))
         @(negedge nclk);
      repeat (2) @(negedge nclk);
   endtask

   task automatic run_status_step(input logic [data_w-1:0] status);
      wait_link_idle();
      link_vld_in  = 1'b1;
      link_data_in = status;
      @(negedge nclk);
      link_vld_in  = 1'b0;
      link_data_in = '0;
      while (dma_queue_info_avail !== 1'b1) @(negedge nclk);
      if (dma_pkt_avail !== status[31:16])
         report_mismatch("pkt_avail", status[31:16], dma_pkt_avail);
      if (dma_can_wr_pkt !== status[15:0])
         report_mismatch("can_wr_pkt", status[15:0], dma_can_wr_pkt);
   endtask

   task automatic run_receive_step(input logic [queue_w-1:0] q, input int len);
      logic [data_w-1:0] data [$];
      int words, total, remaining;
      words = (len + 3) / 4;
      data.push_back(32'(len));
      for (int i = 0; i < words; i++) data.push_back(take_word());
      wait_link_idle();
      saw_overflow   = 1'b0;
      dma_rd_queue   = q;
      dma_rd_request = 1'b1;
      @(negedge nclk);
      dma_rd_request = 1'b0;
      while (link_op_req != op_net_to_cpci) @(negedge nclk);
      if (link_op_queue !== q) report_mismatch("receive queue", 32'(q), 32'(link_op_queue));
      while (link_op_ack != op_net_to_cpci) @(negedge nclk);
      @(negedge nclk);
      // Length word then payload, one word per cycle
      foreach (data[i]) begin
         link_vld_in  = 1'b1;
         link_data_in = data[i];
         @(negedge nclk);
      end
      link_vld_in  = 1'b0;
      link_data_in = '0;
      while (dma_all_in_buf !== 1'b1) @(negedge nclk);
      repeat (2) @(negedge nclk);
      if (saw_overflow !== (data.size() > rx_fifo_depth))
         report_mismatch("overflow", 32'(data.size() > rx_fifo_depth), 32'(saw_overflow));
      // Words past a full FIFO are lost
      total = (data.size() > rx_fifo_depth) ? rx_fifo_depth : data.size();
      for (int i = 0; i < total; i++) begin
         remaining = total - i;
         if (link_nearly_full_out !== (remaining >= rx_nearly_full_level))
            report_mismatch("link_nearly_full_out", 32'(remaining >= rx_nearly_full_level),
                            32'(link_nearly_full_out));
         // Host view of a draining FIFO
         if (dma_nearly_empty !== (remaining <= nearly_empty_level))
            report_mismatch("dma_nearly_empty", 32'(remaining <= nearly_empty_level),
                            32'(dma_nearly_empty));
         if (dma_empty !== 1'b0) report_failure("receive FIFO empty before all words were read");
         if (dma_rd_data !== data[i]) report_mismatch("receive word", data[i], dma_rd_data);
         dma_rd_en = 1'b1;
         @(negedge nclk);
         dma_rd_en = 1'b0;
         @(negedge nclk);
      end
      if (dma_empty !== 1'b1) report_failure("receive FIFO not empty after draining");
      if (dma_nearly_empty !== 1'b1)
         report_mismatch("dma_nearly_empty after drain", 1, 32'(dma_nearly_empty));
   endtask

   task automatic run_transmit_step(input logic [queue_w-1:0] q, input int len);
      logic [data_w-1:0] data [$];
      int words;
      words = (len + 3) / 4;
      for (int i = 0; i < words; i++) data.push_back(take_word());
      wait_link_idle();
      link_seen.delete();
      // Bursts start before the header so it is held off as well
      nf_enable = 1'b1;
      fork
         begin
            // Host writer, header first
            while (!dma_wr_rdy) @(negedge nclk);
            dma_wr_en   = 1'b1;
            dma_wr_data = {12'h000, q, 16'(len)};
            @(negedge nclk);
            foreach (data[i]) begin
               while (!dma_wr_rdy) begin
                  dma_wr_en = 1'b0;
                  @(negedge nclk);
               end
               dma_wr_en   = 1'b1;
               dma_wr_data = data[i];
               @(negedge nclk);
            end
            dma_wr_en = 1'b0;
         end
         begin
            // Link monitor
            while (link_seen.size() < words + 1) begin
               @(negedge nclk);
               if (link_vld_out === 1'b1) begin
                  if (link_seen.size() == 0 && link_op_queue !== q)
                     report_mismatch("transmit queue", 32'(q), 32'(link_op_queue));
                  link_seen.push_back(link_data_out);
               end
            end
            nf_enable = 1'b0;
         end
      join
      if (link_seen[0] !== 32'(len[15:0]))
         report_mismatch("transmit length", 32'(len[15:0]), link_seen[0]);
      foreach (data[i])
         if (link_seen[i+1] !== data[i]) report_mismatch("transmit word", data[i], link_seen[i+1]);
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial begin
      nclk = 1'b0;
      nreset = 1'b1;
      dma_rd_request = 1'b0;
      dma_rd_queue = '0;
      dma_rd_en = 1'b0;
      dma_wr_en = 1'b0;
      dma_wr_data = '0;
      link_op_ack <= op_idle;
      link_vld_in = 1'b0;
      link_data_in = '0;
      link_nearly_full_in <= 1'b0;
      nf_enable = 1'b0;
      saw_overflow = 1'b0;
      burst_left = 0;
      mismatches = 0;
      failures = 0;
      cycles = 0;
      num_steps = 0;
      cycle_limit = 1000;
      lfsr_state = 32'h0093_8754;
      read_steps();
      cycle_limit = 200 * num_steps + 500;
      repeat (4) @(posedge nclk);
      @(negedge nclk);
      nreset = 1'b0;
      @(negedge nclk);
      // State straight after reset
      if (link_op_req !== op_status_query)
         report_mismatch("reset op_req", 32'(op_status_query), 32'(link_op_req));
      if (link_vld_out !== 1'b0) report_mismatch("reset link_vld_out", 0, 32'(link_vld_out));
      if (overflow !== 1'b0) report_mismatch("reset overflow", 0, 32'(overflow));
      if (dma_queue_info_avail !== 1'b0)
         report_mismatch("reset info_avail", 0, 32'(dma_queue_info_avail));
      if (dma_all_in_buf !== 1'b0) report_mismatch("reset all_in_buf", 0, 32'(dma_all_in_buf));
      for (int s = 0; s < num_steps; s++) begin
         case (step_kind[s])
            "S": run_status_step(step_status[s]);
            "R": run_receive_step(step_queue[s], step_len[s]);
            "T": run_transmit_step(step_queue[s], step_len[s]);
            default: report_failure("unknown step kind in data file");
         endcase
      end
      repeat (4) @(negedge nclk);
      $display("steps %0d, mismatches %0d, other errors %0d", num_steps, mismatches, failures);
      if (mismatches == 0 && failures == 0 && num_steps > 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- verif/dma_testdata.txt
# kind queue(hex) byte_length(dec) status_word(hex)
# S polls status, R receives from a queue, T transmits to a queue
S 0 0 a5c30f1e
R 3 20 00000000
S 0 0 0001fffe
T 5 16 00000000
R a 124 00000000
T c 47 00000000
S 0 0 ffff0000
R 1 1 00000000
R 7 160 00000000
R 2 64 00000000
T 0 124 00000000
T f 3 00000000
S 0 0 12345678
R e 37 00000000
T 9 60 00000000
S 0 0 0000ffff
R 4 8 00000000
T 2 200 00000000
S 0 0 deadbeef
